//--- src/ise_pkg.sv
/* Crypto ISE package
   Opcodes, field layout, result codes and MCCR layout for the coprocessor */

package ise_pkg;

    // --------------------------------------------------
    // Major opcode and op classes
    // --------------------------------------------------

    localparam logic [6:0] ise_opcode = 7'b0001011; // custom-0

    // funct3 op-class codes, 7 is unused
    localparam logic [2:0] op_mv2cop  = 3'd0; // rs1 -> CPR
    localparam logic [2:0] op_mv2gpr  = 3'd1; // CPR -> rd
    localparam logic [2:0] op_lui     = 3'd2; // Immediate into one half
    localparam logic [2:0] op_padd    = 3'd3;
    localparam logic [2:0] op_psub    = 3'd4;
    localparam logic [2:0] op_mccr_w  = 3'd5;
    localparam logic [2:0] op_mccr_r  = 3'd6;

    // Pack widths, 5..7 illegal
    localparam logic [2:0] pw_32      = 3'd0;
    localparam logic [2:0] pw_16      = 3'd1;
    localparam logic [2:0] pw_8       = 3'd2;
    localparam logic [2:0] pw_4       = 3'd3;
    localparam logic [2:0] pw_2       = 3'd4;

    // Result codes back to the core
    localparam logic [2:0] res_ok       = 3'd0;
    localparam logic [2:0] res_invalid  = 3'd1; // Bad opcode, funct3 or pw
    localparam logic [2:0] res_disabled = 3'd2; // Pack width switched off

    // --------------------------------------------------
    // MCCR layout
    // --------------------------------------------------

    localparam int mccr_u   = 0;
    localparam int mccr_s   = 1;
    localparam int mccr_r   = 2; // Feature bits from here
    localparam int mccr_mp  = 3;
    localparam int mccr_sg  = 4;
    localparam int mccr_p32 = 5;
    localparam int mccr_p16 = 6;
    localparam int mccr_p8  = 7;
    localparam int mccr_p4  = 8;
    localparam int mccr_p2  = 9;
    localparam int mccr_c0  = 24; // Countermeasures c0..c7 at 24..31

    // Fixed features, bit 0 is r ... bit 7 is p2
    // p4 and p2 not built
    localparam logic [7:0] mccr_features = 8'b0011_1111;

    // Reset image: c0..c7 on, features, S and U on
    localparam logic [31:0] mccr_reset_val = {8'hff, 14'd0, mccr_features, 1'b1, 1'b1};

    // Only S and the countermeasures may be written
    localparam logic [31:0] mccr_wr_mask   = {8'hff, 14'd0, 8'h00, 1'b1, 1'b0};

    // --------------------------------------------------
    // Instruction word, two encodings over one word
    // --------------------------------------------------

    typedef union packed {
        struct packed {
            logic [2:0] pw;       // Pack width
            logic [4:0] rsvd_hi;  // Ignored
            logic [3:0] crs2;
            logic [3:0] crs1;
            logic       rsvd_15;
            logic [2:0] funct3;
            logic       rsvd_11;
            logic [3:0] crd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [15:0] imm16;
            logic        hi;      // 1 selects upper half
            logic [2:0]  funct3;
            logic        rsvd_11;
            logic [3:0]  crd;
            logic [6:0]  opcode;
        } i_fmt;
    } ise_insn_u;

endpackage

//--- src/ise_decode.sv
/* ISE instruction decoder
   Splits an encoding into class, register indices, pack width and immediate */

`timescale 1ns/1ns

module ise_decode (
    input  ise_pkg::ise_insn_u insn,
    output logic [2:0]         op_class,
    output logic [3:0]         crd,
    output logic [3:0]         crs1,
    output logic [3:0]         crs2,
    output logic [2:0]         pw,
    output logic [15:0]        imm16,
    output logic               hi,
    output logic               illegal
);

    logic bad_opcode;  // Not our major opcode
    logic bad_funct3;  // Unused class code
    logic is_packed;   // padd or psub
    logic bad_pw;      // Pack width beyond pw_2

    // --------------------------------------------------
    // Field extraction
    // --------------------------------------------------

    // Register fields sit in the same place for all classes
    assign op_class = insn.r_fmt.funct3;
    assign crd      = insn.r_fmt.crd;
    assign crs1     = insn.r_fmt.crs1;
    assign crs2     = insn.r_fmt.crs2;
    assign pw       = insn.r_fmt.pw;

    // Immediate view, only meaningful for lui
    assign imm16    = insn.i_fmt.imm16;
    assign hi       = insn.i_fmt.hi;

    // --------------------------------------------------
    // Legality
    // --------------------------------------------------

    always_comb begin
        bad_opcode = (insn.r_fmt.opcode != ise_pkg::ise_opcode);
        bad_funct3 = (insn.r_fmt.funct3 == 3'd7);

        // Pack width only matters on the packed ops
        is_packed  = (insn.r_fmt.funct3 == ise_pkg::op_padd) ||
                     (insn.r_fmt.funct3 == ise_pkg::op_psub);

        case (insn.r_fmt.pw)
            ise_pkg::pw_32,
            ise_pkg::pw_16,
            ise_pkg::pw_8,
            ise_pkg::pw_4,
            ise_pkg::pw_2: bad_pw = 1'b0;
            default:       bad_pw = 1'b1; // 5..7
        endcase

        // Valid gating happens in the top
        illegal = bad_opcode || bad_funct3 || (is_packed && bad_pw);
    end

endmodule

//--- src/ise_mccr.sv
/* Machine control register (MCCR)
   Masked writable bits over a fixed image, plus pack-width enable lookup */

`timescale 1ns/1ns

module ise_mccr (
    input  logic        g_clk,
    input  logic        g_reset,
    input  logic        wen,
    input  logic [31:0] wdata,
    input  logic [2:0]  pw,
    output logic [31:0] mccr_value,
    output logic        pw_enabled
);

    logic [31:0] mccr_wr_bits; // Only masked positions ever set

    // --------------------------------------------------
    // Writable state
    // --------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (g_reset) begin
            mccr_wr_bits <= ise_pkg::mccr_reset_val & ise_pkg::mccr_wr_mask;
        end else if (wen) begin
            mccr_wr_bits <= wdata & ise_pkg::mccr_wr_mask; // S and c0..c7
        end
    end

    // Read-only bits always show the reset image
    assign mccr_value = mccr_wr_bits |
                        (ise_pkg::mccr_reset_val & ~ise_pkg::mccr_wr_mask);

    // --------------------------------------------------
    // Feature bit for the requested pack width
    // --------------------------------------------------

    always_comb begin
        case (pw)
            ise_pkg::pw_32: pw_enabled = mccr_value[ise_pkg::mccr_p32];
            ise_pkg::pw_16: pw_enabled = mccr_value[ise_pkg::mccr_p16];
            ise_pkg::pw_8:  pw_enabled = mccr_value[ise_pkg::mccr_p8];
            ise_pkg::pw_4:  pw_enabled = mccr_value[ise_pkg::mccr_p4];
            ise_pkg::pw_2:  pw_enabled = mccr_value[ise_pkg::mccr_p2];
            default:        pw_enabled = 1'b0; // Illegal widths
        endcase
    end

endmodule

//--- src/ise_cprs.sv
/* Coprocessor register file
   16 x 32 bits, two asynchronous reads and one synchronous write */

`timescale 1ns/1ns

module ise_cprs (
    input  logic        g_clk,
    input  logic        g_reset,
    input  logic [3:0]  raddr_a,
    input  logic [3:0]  raddr_b,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b,
    input  logic        wen,
    input  logic [3:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] cprs [16];

    // Write lands at the edge, next read sees it
    always_ff @(posedge g_clk) begin
        if (g_reset) begin
            for (int i = 0; i < 16; i++) begin
                cprs[i] <= '0; // Architecturally zero after reset
            end
        end else if (wen) begin
            cprs[waddr] <= wdata;
        end
    end

    assign rdata_a = cprs[raddr_a];
    assign rdata_b = cprs[raddr_b];

endmodule

//--- src/ise_palu.sv
/* Packed add/subtract unit
   Lane-wise wrapping arithmetic at 32, 16, 8, 4 or 2 bit lanes */

`timescale 1ns/1ns

module ise_palu (
    input  logic [31:0] opa,
    input  logic [31:0] opb,
    input  logic [2:0]  pw,
    input  logic        sub,
    output logic [31:0] result
);

    logic [31:0] lane_start; // 1 at the LSB of every lane
    logic [31:0] opb_x;      // opb or its complement

    // --------------------------------------------------
    // Lane boundaries
    // --------------------------------------------------

    always_comb begin
        case (pw)
            ise_pkg::pw_16: lane_start = 32'h0001_0001;
            ise_pkg::pw_8:  lane_start = 32'h0101_0101;
            ise_pkg::pw_4:  lane_start = 32'h1111_1111;
            ise_pkg::pw_2:  lane_start = 32'h5555_5555;
            default:        lane_start = 32'h0000_0001; // Single 32-bit lane
        endcase
    end

    // Subtract is a + ~b + 1, the +1 enters at each lane start
    assign opb_x = sub ? ~opb : opb;

    // --------------------------------------------------
    // Ripple chain with carry cut at lane starts
    // --------------------------------------------------

    always_comb begin
        logic carry;
        logic p;
        logic g;

        carry = sub;
        for (int i = 0; i < 32; i++) begin
            // New lane, discard carry from below
            if (lane_start[i]) begin
                carry = sub;
            end
            p         = opa[i] ^ opb_x[i];
            g         = opa[i] & opb_x[i];
            result[i] = p ^ carry;
            carry     = g | (p & carry); // Carry out of top lane bit dropped
        end
    end

endmodule

//--- src/ise_top.sv
/* Crypto ISE coprocessor top
   Decodes one instruction per cycle, updates CPR/MCCR state, registers the result */

`timescale 1ns/1ns

module ise_top (
    input  logic        g_clk,
    input  logic        g_reset,
    input  logic        cop_insn_valid,
    input  logic [31:0] cop_insn_enc,
    input  logic [31:0] cop_rs1,
    output logic        cop_result_valid,
    output logic [2:0]  cop_result,
    output logic        cop_rd_wen,
    output logic [31:0] cop_rd_data
);

    logic [2:0]  op_class;
    logic [3:0]  crd, crs1, crs2;
    logic [2:0]  pw;
    logic [15:0] imm16;
    logic        hi;
    logic        illegal;

    logic [31:0] mccr_value;
    logic        pw_enabled;
    logic        mccr_wen;

    logic [3:0]  raddr_b;
    logic [31:0] rdata_a, rdata_b;
    logic        cpr_wen;
    logic [31:0] cpr_wdata;
    logic [31:0] palu_result;

    logic        is_packed, disabled, exec, rd_wen;
    logic [2:0]  result_code;
    logic [31:0] rd_data;

    // --------------------------------------------------
    // Blocks
    // --------------------------------------------------

    ise_decode u_decode (
        .insn     (cop_insn_enc),
        .op_class (op_class),
        .crd      (crd),
        .crs1     (crs1),
        .crs2     (crs2),
        .pw       (pw),
        .imm16    (imm16),
        .hi       (hi),
        .illegal  (illegal)
    );

    ise_mccr u_mccr (
        .g_clk      (g_clk),
        .g_reset    (g_reset),
        .wen        (mccr_wen),
        .wdata      (cop_rs1),
        .pw         (pw),
        .mccr_value (mccr_value),
        .pw_enabled (pw_enabled)
    );

    // lui reads its own destination on port b
    assign raddr_b = (op_class == ise_pkg::op_lui) ? crd : crs2;

    ise_cprs u_cprs (
        .g_clk   (g_clk),
        .g_reset (g_reset),
        .raddr_a (crs1),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .wen     (cpr_wen),
        .waddr   (crd),
        .wdata   (cpr_wdata)
    );

    ise_palu u_palu (
        .opa    (rdata_a),
        .opb    (rdata_b),
        .pw     (pw),
        .sub    (op_class == ise_pkg::op_psub),
        .result (palu_result)
    );

    // --------------------------------------------------
    // Execute control
    // --------------------------------------------------

    always_comb begin
        is_packed = (op_class == ise_pkg::op_padd) || (op_class == ise_pkg::op_psub);
        disabled  = is_packed && !pw_enabled;            // Feature bit off
        exec      = cop_insn_valid && !illegal && !disabled;

        mccr_wen  = exec && (op_class == ise_pkg::op_mccr_w);
        cpr_wen   = exec && ((op_class == ise_pkg::op_mv2cop) ||
                             (op_class == ise_pkg::op_lui)    || is_packed);
        rd_wen    = exec && ((op_class == ise_pkg::op_mv2gpr) ||
                             (op_class == ise_pkg::op_mccr_r));

        // Invalid wins over disabled
        if (illegal)       result_code = ise_pkg::res_invalid;
        else if (disabled) result_code = ise_pkg::res_disabled;
        else               result_code = ise_pkg::res_ok;

        // CPR write data
        case (op_class)
            ise_pkg::op_mv2cop: cpr_wdata = cop_rs1;
            ise_pkg::op_lui:    cpr_wdata = hi ? {imm16, rdata_b[15:0]}
                                               : {rdata_b[31:16], imm16};
            default:            cpr_wdata = palu_result; // padd / psub
        endcase

        // rd data, zero unless a read actually retires
        if (!rd_wen)                              rd_data = '0;
        else if (op_class == ise_pkg::op_mccr_r)  rd_data = mccr_value;
        else                                      rd_data = rdata_a;
    end

    // --------------------------------------------------
    // Output registers
    // --------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (g_reset) begin
            cop_result_valid <= 1'b0;
            cop_rd_wen       <= 1'b0;
        end else begin
            cop_result_valid <= cop_insn_valid; // One cycle after strobe
            cop_rd_wen       <= rd_wen;
        end
    end

    always_ff @(posedge g_clk) begin
        cop_result  <= result_code;
        cop_rd_data <= rd_data;
    end

endmodule

//--- testbench/tb_ise.sv
/* Testbench for the crypto ISE coprocessor
   Directed and random instructions checked against a shadow CPR/MCCR model */

`timescale 1ns/1ns

module tb_ise;

    localparam int max_cycles = 600; // About twice the ~280 stimulus cycles

    logic        g_clk;
    logic        g_reset;
    logic        cop_insn_valid;
    logic [31:0] cop_insn_enc;
    logic [31:0] cop_rs1;
    logic        cop_result_valid;
    logic [2:0]  cop_result;
    logic        cop_rd_wen;
    logic [31:0] cop_rd_data;

    logic [31:0] shadow_cpr [16];  // Reference CPR state
    logic [31:0] shadow_mccr;      // Reference MCCR
    logic [31:0] rng_state;
    int          cycles = 0;

    // Expected record set at drive time and latched at the next edge
    logic        drv_valid, exp_valid;
    logic [2:0]  drv_result, exp_result;
    logic        drv_rd_wen, exp_rd_wen;
    logic [31:0] drv_rd_data, exp_rd_data;

    ise_top uut (
        .g_clk            (g_clk),
        .g_reset          (g_reset),
        .cop_insn_valid   (cop_insn_valid),
        .cop_insn_enc     (cop_insn_enc),
        .cop_rs1          (cop_rs1),
        .cop_result_valid (cop_result_valid),
        .cop_result       (cop_result),
        .cop_rd_wen       (cop_rd_wen),
        .cop_rd_data      (cop_rd_data)
    );

    always #4 g_clk = ~g_clk; // 8 ns period

    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: test still running after %0d clock cycles", max_cycles);
            $display("Verification failed");
            $fatal(1, "Simulation timed out");
        end
    end

    always @(posedge g_clk) begin
        exp_valid   <= drv_valid;   // Outputs for this one appear now
        exp_result  <= drv_result;
        exp_rd_wen  <= drv_rd_wen;
        exp_rd_data <= drv_rd_data;
    end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, want);
        $display("Verification failed");
        $fatal(1, "Stopping at first error");
    endtask

    // --------------------------------------------------
    // Output checks sampled mid-cycle
    // --------------------------------------------------

    a_valid: assert property (@(negedge g_clk) disable iff (g_reset)
        cop_result_valid == exp_valid)
        else report_mismatch("cop_result_valid", {31'd0, cop_result_valid}, {31'd0, exp_valid});
    a_result: assert property (@(negedge g_clk) disable iff (g_reset)
        !exp_valid || cop_result == exp_result)
        else report_mismatch("cop_result", {29'd0, cop_result}, {29'd0, exp_result});
    a_rd_wen: assert property (@(negedge g_clk) disable iff (g_reset)
        cop_rd_wen == exp_rd_wen)
        else report_mismatch("cop_rd_wen", {31'd0, cop_rd_wen}, {31'd0, exp_rd_wen});
    a_rd_data: assert property (@(negedge g_clk) disable iff (g_reset)
        !exp_valid || cop_rd_data == exp_rd_data)
        else report_mismatch("cop_rd_data", cop_rd_data, exp_rd_data);

    // --------------------------------------------------
    // Encoding helpers and reference arithmetic
    // --------------------------------------------------

    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13); // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [3:0] rd,
                                          input logic [3:0] sa, input logic [3:0] sb,
                                          input logic [2:0] pwv);
        return {pwv, 5'd0, sb, sa, 1'b0, f3, 1'b0, rd, ise_pkg::ise_opcode};
    endfunction

    function automatic logic [31:0] enc_i(input logic [15:0] imm, input logic hi,
                                          input logic [3:0] rd);
        return {imm, hi, ise_pkg::op_lui, 1'b0, rd, ise_pkg::ise_opcode};
    endfunction

    function automatic int lane_width(input logic [2:0] pwv);
        case (pwv)
            ise_pkg::pw_32: return 32;
            ise_pkg::pw_16: return 16;
            ise_pkg::pw_8:  return 8;
            ise_pkg::pw_4:  return 4;
            default:        return 2;
        endcase
    endfunction

    // Feature bit in the shadow MCCR for a pack width
    function automatic logic pw_feature_on(input logic [2:0] pwv);
        case (pwv)
            ise_pkg::pw_32: return shadow_mccr[ise_pkg::mccr_p32];
            ise_pkg::pw_16: return shadow_mccr[ise_pkg::mccr_p16];
            ise_pkg::pw_8:  return shadow_mccr[ise_pkg::mccr_p8];
            ise_pkg::pw_4:  return shadow_mccr[ise_pkg::mccr_p4];
            default:        return shadow_mccr[ise_pkg::mccr_p2];
        endcase
    endfunction

    // Each lane added or subtracted and wrapped to its own width
    function automatic logic [31:0] lane_arith(input logic [31:0] a, input logic [31:0] b,
                                               input int width, input logic sub);
        logic [31:0] mask;
        logic [31:0] la, lb, lr, r;
        mask = (width == 32) ? 32'hffff_ffff : ((32'd1 << width) - 32'd1);
        r    = '0;
        for (int base = 0; base < 32; base += width) begin
            la = (a >> base) & mask;
            lb = (b >> base) & mask;
            lr = (sub ? la - lb : la + lb) & mask;
            r  = r | (lr << base);
        end
        return r;
    endfunction

    // --------------------------------------------------
    // Drivers
    // --------------------------------------------------

    // One valid instruction with the reference model stepped alongside
    task automatic issue(input logic [31:0] insn, input logic [31:0] rs1);
        logic [2:0] f3;
        logic [2:0] pwv;
        logic [3:0] rd, sa, sb;
        logic       packed_op;
        f3        = insn[14:12];
        pwv       = insn[31:29];
        rd        = insn[10:7];
        sa        = insn[19:16];
        sb        = insn[23:20];
        packed_op = (f3 == ise_pkg::op_padd) || (f3 == ise_pkg::op_psub);
        @(posedge g_clk);
        #1;
        cop_insn_valid = 1'b1;
        cop_insn_enc   = insn;
        cop_rs1        = rs1;
        drv_valid      = 1'b1;
        drv_result     = ise_pkg::res_ok;
        drv_rd_wen     = 1'b0;
        drv_rd_data    = '0;
        if (insn[6:0] != ise_pkg::ise_opcode || f3 == 3'd7 || (packed_op && pwv > 3'd4)) begin
            drv_result = ise_pkg::res_invalid;      // No state touched
        end else if (packed_op && !pw_feature_on(pwv)) begin
            drv_result = ise_pkg::res_disabled;
        end else begin
            case (f3)
                ise_pkg::op_mv2cop: shadow_cpr[rd] = rs1;
                ise_pkg::op_mv2gpr: begin
                    drv_rd_wen  = 1'b1;
                    drv_rd_data = shadow_cpr[sa];
                end
                ise_pkg::op_lui: begin
                    if (insn[15]) shadow_cpr[rd][31:16] = insn[31:16];
                    else          shadow_cpr[rd][15:0]  = insn[31:16];
                end
                ise_pkg::op_padd: shadow_cpr[rd] =
                    lane_arith(shadow_cpr[sa], shadow_cpr[sb], lane_width(pwv), 1'b0);
                ise_pkg::op_psub: shadow_cpr[rd] =
                    lane_arith(shadow_cpr[sa], shadow_cpr[sb], lane_width(pwv), 1'b1);
                ise_pkg::op_mccr_w: shadow_mccr = (rs1 & ise_pkg::mccr_wr_mask) |
                                                  (shadow_mccr & ~ise_pkg::mccr_wr_mask);
                default: begin                      // mccr_r
                    drv_rd_wen  = 1'b1;
                    drv_rd_data = shadow_mccr;
                end
            endcase
        end
    endtask

    // Strobe low with a CPR3 write sitting on the bus
    task automatic idle();
        @(posedge g_clk);
        #1;
        cop_insn_valid = 1'b0;
        cop_insn_enc   = enc_r(ise_pkg::op_mv2cop, 4'd3, 4'd0, 4'd0, 3'd0);
        cop_rs1        = rand32();
        drv_valid      = 1'b0;
        drv_result     = ise_pkg::res_ok;
        drv_rd_wen     = 1'b0;
        drv_rd_data    = '0;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        logic [31:0] va, vb;
        g_clk          = 1'b0;
        g_reset        = 1'b1;
        cop_insn_valid = 1'b0;
        cop_insn_enc   = '0;
        cop_rs1        = '0;
        drv_valid      = 1'b0;
        drv_result     = '0;
        drv_rd_wen     = 1'b0;
        drv_rd_data    = '0;
        rng_state      = 32'h227e;
        shadow_mccr    = ise_pkg::mccr_reset_val;
        for (int i = 0; i < 16; i++) begin
            shadow_cpr[i] = '0;
        end
        repeat (10) @(posedge g_clk);
        #1;
        g_reset = 1'b0;
        @(negedge g_clk);
        assert (cop_result_valid === 1'b0 && cop_rd_wen === 1'b0)
            else report_mismatch("valid/rd_wen after reset",
                                 {30'd0, cop_result_valid, cop_rd_wen}, 32'd0);

        // Reset state readback
        issue(enc_r(ise_pkg::op_mccr_r, 4'd0, 4'd0, 4'd0, 3'd0), rand32());
        for (int i = 0; i < 16; i++) begin
            issue(enc_r(ise_pkg::op_mv2gpr, 4'd0, 4'(i), 4'd0, 3'd0), 32'd0);
        end

        // Random moves in and out, back to back
        repeat (32) begin
            va = rand32();
            vb = rand32();
            issue(enc_r(ise_pkg::op_mv2cop, va[3:0], 4'd0, 4'd0, 3'd0), vb);
            va = rand32();
            issue(enc_r(ise_pkg::op_mv2gpr, 4'd0, va[3:0], 4'd0, 3'd0), 32'd0);
        end

        // MCCR masked writes of random data and then its complement
        repeat (2) begin
            va = rand32();
            issue(enc_r(ise_pkg::op_mccr_w, 4'd0, 4'd0, 4'd0, 3'd0), va);
            issue(enc_r(ise_pkg::op_mccr_r, 4'd0, 4'd0, 4'd0, 3'd0), 32'd0);
            issue(enc_r(ise_pkg::op_mccr_w, 4'd0, 4'd0, 4'd0, 3'd0), ~va);
            issue(enc_r(ise_pkg::op_mccr_r, 4'd0, 4'd0, 4'd0, 3'd0), 32'd0);
        end

        // lui into each half of CPR 7
        issue(enc_r(ise_pkg::op_mv2cop, 4'd7, 4'd0, 4'd0, 3'd0), rand32());
        va = rand32();
        issue(enc_i(va[15:0], 1'b1, 4'd7), 32'd0);
        issue(enc_r(ise_pkg::op_mv2gpr, 4'd0, 4'd7, 4'd0, 3'd0), 32'd0);
        issue(enc_i(va[31:16], 1'b0, 4'd7), 32'd0);
        issue(enc_r(ise_pkg::op_mv2gpr, 4'd0, 4'd7, 4'd0, 3'd0), 32'd0);

        // Packed add/sub of CPR1 and CPR2 into CPR3 at the built widths
        for (int p = 0; p < 3; p++) begin
            for (int s = 0; s < 2; s++) begin
                repeat (6) begin
                    issue(enc_r(ise_pkg::op_mv2cop, 4'd1, 4'd0, 4'd0, 3'd0), rand32());
                    issue(enc_r(ise_pkg::op_mv2cop, 4'd2, 4'd0, 4'd0, 3'd0), rand32());
                    issue(enc_r((s != 0) ? ise_pkg::op_psub : ise_pkg::op_padd,
                                4'd3, 4'd1, 4'd2, 3'(p)), 32'd0);
                    issue(enc_r(ise_pkg::op_mv2gpr, 4'd0, 4'd3, 4'd0, 3'd0), 32'd0);
                end
            end
        end
        for (int p = 3; p < 5; p++) begin                 // Widths 4 and 2 not built
            issue(enc_r(ise_pkg::op_padd, 4'd3, 4'd1, 4'd2, 3'(p)), 32'd0);
            issue(enc_r(ise_pkg::op_psub, 4'd3, 4'd1, 4'd2, 3'(p)), 32'd0);
            issue(enc_r(ise_pkg::op_mv2gpr, 4'd0, 4'd3, 4'd0, 3'd0), 32'd0);
        end

        // Illegal encodings leave CPR3 alone
        va = enc_r(ise_pkg::op_mv2cop, 4'd3, 4'd0, 4'd0, 3'd0) ^ 32'h0000_0040;
        issue(va, rand32());                              // Wrong major opcode
        issue(enc_r(3'd7, 4'd3, 4'd1, 4'd2, 3'd0), rand32());
        issue(enc_r(ise_pkg::op_padd, 4'd3, 4'd1, 4'd2, 3'd6), 32'd0);
        issue(enc_r(ise_pkg::op_mv2gpr, 4'd0, 4'd3, 4'd0, 3'd0), 32'd0);

        // Strobe low gives no result and no write
        idle();
        idle();
        issue(enc_r(ise_pkg::op_mv2gpr, 4'd0, 4'd3, 4'd0, 3'd0), 32'd0);
        idle();
        repeat (2) @(posedge g_clk);
        @(negedge g_clk);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- src.f
src/ise_pkg.sv
src/ise_decode.sv
src/ise_mccr.sv
src/ise_cprs.sv
src/ise_palu.sv
src/ise_top.sv
testbench/tb_ise.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ISE coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_ise -f src.f -o sim_ise
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/sim_ise 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Verification passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
